//--- source/nes_input_cfg.svh
// register map and timing constants for the controller-input block
// pad timing is shortened for simulation; scale NES_PAD_HALF_PERIOD for real pads
// addresses are single bytes on the host Wishbone bus

`ifndef NES_INPUT_CFG_SVH
`define NES_INPUT_CFG_SVH

// host register addresses
`define NES_REG_LOADER_CONF 8'h35
`define NES_REG_BTN_P1      8'h40
`define NES_REG_BTN_P2      8'h41

// clk cycles per half period of latch and clock pulses
`define NES_PAD_HALF_PERIOD 4

// clk cycles between poll starts, must exceed one full poll
`define NES_PAD_POLL_CYCLES 256

// clk cycles per autofire half period
`define NES_AUTOFIRE_PERIOD 64

`endif

//--- source/nes_input_pkg.sv
// types shared by the controller-input subsystem
// buttons are active high inside the design, Dualshock bytes arrive active low

`default_nettype none

package nes_input_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] reg_addr_t;

  // bit 7..0 = R, L, D, U, START, SELECT, B, A
  typedef logic [7:0] nes_buttons_t;

  // decoded Dualshock report, active low
  // digital0: L7 D6 R5 U4 St3 Se0, digital1: square7 cross6 circle5 triangle4
  typedef struct packed {
    byte_t digital0;
    byte_t digital1;
  } ds2_report_t;

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    byte_t     dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    byte_t dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    LATCH,
    SAMPLE,
    CLOCK_HI,
    DONE
  } pad_state_e;

endpackage

`default_nettype wire

//--- source/host_regs.sv
// Wishbone classic slave, one ack per transfer, no wait states beyond the ack cycle
// unmapped addresses ack with zero data and drop writes
// a host holding stb after ack starts a second transfer

`timescale 1ns/1ps
`default_nettype none

`include "nes_input_cfg.svh"

module host_regs (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  nes_input_pkg::wb_req_t      i_wb,
  output nes_input_pkg::wb_rsp_t      o_wb,
  output logic                        o_loader_hold,
  output nes_input_pkg::nes_buttons_t o_host_btn_p1,
  output nes_input_pkg::nes_buttons_t o_host_btn_p2
);
  import nes_input_pkg::*;

  byte_t        loader_conf_q;  // bit 0 holds the loader
  nes_buttons_t btn_p1_q;
  nes_buttons_t btn_p2_q;
  byte_t        rd_dat_q;
  logic         ack_q;
  logic         xfer;

  // first cycle of a transfer, the ack cycle itself is excluded
  assign xfer = i_wb.cyc && i_wb.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      ack_q         <= 1'b0;
      loader_conf_q <= '0;
      btn_p1_q      <= '0;
      btn_p2_q      <= '0;
    end else begin
      ack_q <= xfer;
      if (xfer && i_wb.we) begin
        case (i_wb.adr)
          `NES_REG_LOADER_CONF: loader_conf_q <= i_wb.dat;
          `NES_REG_BTN_P1:      btn_p1_q      <= i_wb.dat;
          `NES_REG_BTN_P2:      btn_p2_q      <= i_wb.dat;
          default:              ;  // unmapped, ignored
        endcase
      end
    end
  end

  // read data captured with the ack, old value on a write cycle
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      rd_dat_q <= '0;
    end else if (xfer) begin
      case (i_wb.adr)
        `NES_REG_LOADER_CONF: rd_dat_q <= loader_conf_q;
        `NES_REG_BTN_P1:      rd_dat_q <= btn_p1_q;
        `NES_REG_BTN_P2:      rd_dat_q <= btn_p2_q;
        default:              rd_dat_q <= '0;
      endcase
    end
  end

  assign o_wb.ack = ack_q;
  assign o_wb.dat = rd_dat_q;   // valid while ack is high

  assign o_loader_hold = loader_conf_q[0];
  assign o_host_btn_p1 = btn_p1_q;
  assign o_host_btn_p2 = btn_p2_q;

endmodule

`default_nettype wire

//--- source/nes_pad_reader.sv
// polls an original NES gamepad: latch pulse, then 8 samples with clock pulses between
// pad data is active low, first bit is A and last is R
// buttons hold their value between polls, o_valid marks a fresh read

`timescale 1ns/1ps
`default_nettype none

`include "nes_input_cfg.svh"

module nes_pad_reader (
  input  logic                        clk,
  input  logic                        sys_resetn,
  output logic                        o_pad_latch,
  output logic                        o_pad_clk,
  input  logic                        i_pad_data,
  output nes_input_pkg::nes_buttons_t o_buttons,
  output logic                        o_valid
);
  import nes_input_pkg::*;

  localparam int HALF   = `NES_PAD_HALF_PERIOD;
  localparam int POLL   = `NES_PAD_POLL_CYCLES;
  localparam int HALF_W = $clog2(HALF + 1);
  localparam int POLL_W = $clog2(POLL);

  pad_state_e        state_q;
  logic [POLL_W-1:0] poll_cnt_q;
  logic [HALF_W-1:0] half_cnt_q;
  logic [2:0]        bit_cnt_q;
  nes_buttons_t      shift_q;
  nes_buttons_t      buttons_q;
  logic              poll_tick;
  logic              half_done;

  assign poll_tick = (poll_cnt_q == POLL_W'(POLL - 1));
  assign half_done = (half_cnt_q == HALF_W'(HALF - 1));

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      state_q    <= IDLE;
      poll_cnt_q <= '0;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      buttons_q  <= '0;
    end else begin
      poll_cnt_q <= poll_tick ? '0 : poll_cnt_q + 1'b1;  // free running
      half_cnt_q <= half_done ? '0 : half_cnt_q + 1'b1;
      case (state_q)
        IDLE: begin
          half_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (poll_tick) state_q <= LATCH;
        end
        LATCH: begin
          if (half_done) state_q <= SAMPLE;
        end
        SAMPLE: begin
          if (half_done) begin
            if (bit_cnt_q == 3'd7) begin
              state_q   <= DONE;
              buttons_q <= {~i_pad_data, shift_q[7:1]};  // last bit is R
            end else begin
              state_q   <= CLOCK_HI;
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        CLOCK_HI: begin
          if (half_done) state_q <= SAMPLE;
        end
        default: state_q <= IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  // inverted bits enter at the top, A ends up in bit 0
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q <= '0;
    end else if (state_q == SAMPLE && half_done) begin
      shift_q <= {~i_pad_data, shift_q[7:1]};
    end
  end

  assign o_pad_latch = (state_q == LATCH);
  assign o_pad_clk   = (state_q == CLOCK_HI);
  assign o_buttons   = buttons_q;
  assign o_valid     = (state_q == DONE);  // one cycle after the eighth sample

endmodule

`default_nettype wire

//--- source/button_mapper.sv
// merges pad, Dualshock and host buttons for one player into one NES byte
// autofire runs on square (B) and triangle (A) with a shared phase counter
// home combo is Select plus Down from pad and Dualshock only

`timescale 1ns/1ps
`default_nettype none

`include "nes_input_cfg.svh"

module button_mapper (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  nes_input_pkg::nes_buttons_t i_pad_btn,
  input  nes_input_pkg::ds2_report_t  i_ds2,
  input  nes_input_pkg::nes_buttons_t i_host_btn,
  output nes_input_pkg::nes_buttons_t o_buttons,
  output logic                        o_home_combo
);
  import nes_input_pkg::*;

  localparam int AF_PERIOD = `NES_AUTOFIRE_PERIOD;
  localparam int AF_W      = $clog2(AF_PERIOD);

  logic [AF_W-1:0] af_cnt_q;
  logic            af_phase_q;
  logic            square_held;
  logic            triangle_held;
  logic            auto_square;
  logic            auto_triangle;
  nes_buttons_t    ds2_btn;
  nes_buttons_t    local_btn;    // pad plus Dualshock
  nes_buttons_t    buttons_q;
  logic            home_q;

  // free running, phase flips every AF_PERIOD cycles
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      af_cnt_q   <= '0;
      af_phase_q <= 1'b0;
    end else if (af_cnt_q == AF_W'(AF_PERIOD - 1)) begin
      af_cnt_q   <= '0;
      af_phase_q <= ~af_phase_q;
    end else begin
      af_cnt_q <= af_cnt_q + 1'b1;
    end
  end

  assign square_held   = ~i_ds2.digital1[7];
  assign triangle_held = ~i_ds2.digital1[4];
  assign auto_square   = square_held & af_phase_q;    // 0 when released
  assign auto_triangle = triangle_held & af_phase_q;

  // R L D U START SELECT B A
  assign ds2_btn = {~i_ds2.digital0[5], ~i_ds2.digital0[7], ~i_ds2.digital0[6],
                    ~i_ds2.digital0[4], ~i_ds2.digital0[3], ~i_ds2.digital0[0],
                    ~i_ds2.digital1[6] | auto_square,
                    ~i_ds2.digital1[5] | auto_triangle};

  assign local_btn = i_pad_btn | ds2_btn;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      buttons_q <= '0;
      home_q    <= 1'b0;
    end else begin
      buttons_q <= local_btn | i_host_btn;
      home_q    <= local_btn[2] & local_btn[5];  // SELECT and D
    end
  end

  assign o_buttons    = buttons_q;
  assign o_home_combo = home_q;

endmodule

`default_nettype wire

//--- source/joypad_port.sv
// console-side controller shift register for one port
// strobe high reloads every cycle, falling joypad clock shifts right with 0 fill

`timescale 1ns/1ps
`default_nettype none

module joypad_port (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  nes_input_pkg::nes_buttons_t i_buttons,
  input  logic                        i_strobe,
  input  logic                        i_joy_clk,
  output logic                        o_data
);
  import nes_input_pkg::*;

  nes_buttons_t shift_q;
  logic         joy_clk_q;   // previous sample of the port clock

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q   <= '0;
      joy_clk_q <= 1'b0;
    end else begin
      joy_clk_q <= i_joy_clk;
      if (i_strobe) begin
        shift_q <= i_buttons;
      end else if (joy_clk_q && !i_joy_clk) begin
        shift_q <= {1'b0, shift_q[7:1]};  // next button into bit 0
      end
    end
  end

  assign o_data = shift_q[0];

endmodule

`default_nettype wire

//--- source/nes_input_top.sv
// controller-input subsystem: host registers, two NES pad readers,
// two button mappers and two console joypad ports
// index 0 of every 2-bit port is player 1

`timescale 1ns/1ps
`default_nettype none

module nes_input_top (
  input  logic                       clk,
  input  logic                       sys_resetn,
  input  nes_input_pkg::wb_req_t     i_wb,
  output nes_input_pkg::wb_rsp_t     o_wb,
  output logic                       o_loader_hold,
  output logic [1:0]                 o_pad_latch,
  output logic [1:0]                 o_pad_clk,
  input  logic [1:0]                 i_pad_data,
  input  nes_input_pkg::ds2_report_t i_ds2_p1,
  input  nes_input_pkg::ds2_report_t i_ds2_p2,
  input  logic [1:0]                 i_joy_strobe,
  input  logic [1:0]                 i_joy_clk,
  output logic [1:0]                 o_joy_data,
  output logic                       o_soft_reset
);
  import nes_input_pkg::*;

  nes_buttons_t host_btn_p1;
  nes_buttons_t host_btn_p2;
  nes_buttons_t pad_btn_p1;
  nes_buttons_t pad_btn_p2;
  nes_buttons_t merged_p1;
  nes_buttons_t merged_p2;

  host_regs u_host_regs (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_wb          (i_wb),
    .o_wb          (o_wb),
    .o_loader_hold (o_loader_hold),
    .o_host_btn_p1 (host_btn_p1),
    .o_host_btn_p2 (host_btn_p2)
  );

  // pad buttons hold between polls, so the valid pulse is not needed here
  nes_pad_reader u_pad_p1 (
    .clk (clk), .sys_resetn (sys_resetn),
    .o_pad_latch (o_pad_latch[0]), .o_pad_clk (o_pad_clk[0]), .i_pad_data (i_pad_data[0]),
    .o_buttons (pad_btn_p1), .o_valid ()
  );

  nes_pad_reader u_pad_p2 (
    .clk (clk), .sys_resetn (sys_resetn),
    .o_pad_latch (o_pad_latch[1]), .o_pad_clk (o_pad_clk[1]), .i_pad_data (i_pad_data[1]),
    .o_buttons (pad_btn_p2), .o_valid ()
  );

  button_mapper u_map_p1 (
    .clk (clk), .sys_resetn (sys_resetn),
    .i_pad_btn (pad_btn_p1), .i_ds2 (i_ds2_p1), .i_host_btn (host_btn_p1),
    .o_buttons (merged_p1), .o_home_combo (o_soft_reset)  // Home only on player 1
  );

  button_mapper u_map_p2 (
    .clk (clk), .sys_resetn (sys_resetn),
    .i_pad_btn (pad_btn_p2), .i_ds2 (i_ds2_p2), .i_host_btn (host_btn_p2),
    .o_buttons (merged_p2), .o_home_combo ()
  );

  joypad_port u_joy_p1 (
    .clk (clk), .sys_resetn (sys_resetn), .i_buttons (merged_p1),
    .i_strobe (i_joy_strobe[0]), .i_joy_clk (i_joy_clk[0]), .o_data (o_joy_data[0])
  );

  joypad_port u_joy_p2 (
    .clk (clk), .sys_resetn (sys_resetn), .i_buttons (merged_p2),
    .i_strobe (i_joy_strobe[1]), .i_joy_clk (i_joy_clk[1]), .o_data (o_joy_data[1])
  );

endmodule

`default_nettype wire

//--- tests/nes_input_properties.sv
// protocol checks bound into the Wishbone slave and both pad readers
// each bound instance keeps a failure count that the testbench adds to its summary
// ports a bind does not need are tied low

`timescale 1ns/1ps
`default_nettype none

module nes_input_properties (
  input logic clk,
  input logic sys_resetn,
  input logic i_cyc,
  input logic i_stb,
  input logic i_ack,
  input logic i_pad_latch,
  input logic i_pad_clk
);
  int fail_cnt = 0;

  // ack only answers a live strobe
  a_ack_with_stb: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_ack |-> (i_cyc && i_stb))
    else begin
      fail_cnt++;
      $error("ack raised without cyc and stb");
    end

  // one ack per transfer, never two in a row
  a_ack_one_cycle: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_ack |=> !i_ack)
    else begin
      fail_cnt++;
      $error("ack held for two cycles");
    end

  a_latch_clk_apart: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(i_pad_latch && i_pad_clk))
    else begin
      fail_cnt++;
      $error("pad latch and pad clock high together");
    end

endmodule

bind host_regs nes_input_properties u_props (
  .clk (clk), .sys_resetn (sys_resetn),
  .i_cyc (i_wb.cyc), .i_stb (i_wb.stb), .i_ack (o_wb.ack),
  .i_pad_latch (1'b0), .i_pad_clk (1'b0)
);

bind nes_pad_reader nes_input_properties u_props (
  .clk (clk), .sys_resetn (sys_resetn),
  .i_cyc (1'b0), .i_stb (1'b0), .i_ack (1'b0),
  .i_pad_latch (o_pad_latch), .i_pad_clk (o_pad_clk)
);

`default_nettype wire

//--- tests/tb_nes_input.sv
// directed testbench for the controller-input subsystem
// pad models answer the readers, Dualshock reports are driven directly
// run length is bounded by a watchdog sized in pad poll periods

`timescale 1ns/1ps
`default_nettype none

`include "nes_input_cfg.svh"

module tb_nes_input;
  import nes_input_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int POLL         = `NES_PAD_POLL_CYCLES;
  localparam int TEST_POLLS   = 10;  // rough sum of all test lengths
  localparam int MARGIN_POLLS = 6;
  localparam int WATCHDOG_NS  = (TEST_POLLS + MARGIN_POLLS) * POLL * CLK_PERIOD;

  logic        clk;
  logic        sys_resetn;
  wb_req_t     i_wb;
  wb_rsp_t     o_wb;
  logic        o_loader_hold;
  logic [1:0]  o_pad_latch;
  logic [1:0]  o_pad_clk;
  logic [1:0]  i_pad_data;
  ds2_report_t i_ds2_p1;
  ds2_report_t i_ds2_p2;
  logic [1:0]  i_joy_strobe;
  logic [1:0]  i_joy_clk;
  logic [1:0]  o_joy_data;
  logic        o_soft_reset;

  int           errors = 0;
  int           assert_fails;
  integer       seed = 32'h35fb;
  nes_buttons_t pad_btn [2];                     // buttons held on each pad
  logic [7:0]   pad_sr [2] = '{8'hff, 8'hff};    // active low on the wire
  logic [1:0]   pad_clk_q = '0;

  nes_input_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // 4021-style pad: latch loads, rising pad clock shifts the next button out
  always @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (o_pad_latch[p]) pad_sr[p] <= ~pad_btn[p];
      else if (o_pad_clk[p] && !pad_clk_q[p]) pad_sr[p] <= {1'b1, pad_sr[p][7:1]};
    end
    pad_clk_q <= o_pad_clk;
  end

  assign i_pad_data = {pad_sr[1][0], pad_sr[0][0]};

  function automatic byte_t rand_byte();
    return byte_t'($random(seed));
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_buttons(input string name, input nes_buttons_t got,
                               input nes_buttons_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // holds the request until ack, then drops cyc and stb
  task automatic wait_ack(output byte_t rdata);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!o_wb.ack && n < 16);
    if (!o_wb.ack) begin
      errors++;
      $display("Wishbone transfer to address 0x%h got no ack", i_wb.adr);
    end
    rdata = o_wb.dat;
    @(posedge clk);
    i_wb <= '0;
  endtask

  task automatic wb_write(input reg_addr_t adr, input byte_t dat);
    byte_t unused;
    @(posedge clk);
    i_wb <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_ack(unused);
  endtask

  task automatic wb_read(input reg_addr_t adr, output byte_t dat);
    @(posedge clk);
    i_wb <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
    wait_ack(dat);
  endtask

  // strobe, then ten clocks; bits 8 and 9 come from the zero fill
  task automatic joy_read(input int port, output nes_buttons_t btn, output logic [1:0] tail);
    logic [9:0] bits;
    @(posedge clk);
    i_joy_strobe[port] <= 1'b1;
    @(posedge clk);
    i_joy_strobe[port] <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      bits[i] = o_joy_data[port];
      @(posedge clk);
      i_joy_clk[port] <= 1'b1;
      @(posedge clk);
      i_joy_clk[port] <= 1'b0;
      @(posedge clk);  // shift lands here
    end
    btn  = bits[7:0];
    tail = bits[9:8];
  endtask

  task automatic test_registers();
    byte_t conf;
    byte_t b1;
    byte_t b2;
    byte_t rd;
    conf = rand_byte();
    b1   = rand_byte();
    b2   = rand_byte();
    wb_write(`NES_REG_LOADER_CONF, conf);
    wb_write(`NES_REG_BTN_P1, b1);
    wb_write(`NES_REG_BTN_P2, b2);
    wb_write(8'h77, 8'ha5);
    wb_read(`NES_REG_LOADER_CONF, rd);
    check_byte("loader_conf", rd, conf);
    wb_read(`NES_REG_BTN_P1, rd);
    check_byte("host_btn_p1", rd, b1);
    wb_read(`NES_REG_BTN_P2, rd);
    check_byte("host_btn_p2", rd, b2);
    wb_read(8'h77, rd);
    check_byte("unmapped 0x77", rd, 8'h00);
    @(negedge clk);
    check_bit("o_loader_hold", o_loader_hold, conf[0]);
    wb_write(`NES_REG_LOADER_CONF, conf ^ 8'h01);
    @(negedge clk);
    check_bit("o_loader_hold", o_loader_hold, ~conf[0]);
    wb_write(`NES_REG_BTN_P1, 8'h00);
    wb_write(`NES_REG_BTN_P2, 8'h00);
  endtask

  task automatic test_host_buttons();
    nes_buttons_t exp;
    nes_buttons_t got;
    logic [1:0]   tail;
    exp = rand_byte();
    wb_write(`NES_REG_BTN_P2, exp);
    repeat (4) @(posedge clk);
    joy_read(1, got, tail);
    check_buttons("o_joy_data[1] host byte", got, exp);
    check_bit("o_joy_data[1] bit 8", tail[0], 1'b0);
    check_bit("o_joy_data[1] bit 9", tail[1], 1'b0);
    wb_write(`NES_REG_BTN_P2, 8'h00);
  endtask

  task automatic test_nes_pad();
    nes_buttons_t exp [2];
    nes_buttons_t got;
    logic [1:0]   tail;
    exp[0] = rand_byte();
    exp[1] = rand_byte();
    @(posedge clk);
    pad_btn[0] <= exp[0];
    pad_btn[1] <= exp[1];
    repeat (2 * POLL + 4) @(posedge clk);
    joy_read(0, got, tail);
    check_buttons("o_joy_data[0] pad byte", got, exp[0]);
    joy_read(1, got, tail);
    check_buttons("o_joy_data[1] pad byte", got, exp[1]);
    pad_btn[0] <= 8'h00;
    pad_btn[1] <= 8'h00;
    repeat (2 * POLL) @(posedge clk);
  endtask

  task automatic test_ds2_mapping();
    // report bit (digital0 in 15:8) and the NES bit it must set
    int           rep_bit [6] = '{15, 14, 13, 12, 11, 8};
    int           nes_bit [6] = '{6, 5, 7, 4, 3, 2};
    nes_buttons_t got;
    logic [1:0]   tail;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i < 6) i_ds2_p1 <= ds2_report_t'(~(16'h1 << rep_bit[i]));
      else i_ds2_p1 <= ds2_report_t'(~(16'h1 << (12 - i)));  // cross 6, circle 5
      repeat (2) @(posedge clk);
      joy_read(0, got, tail);
      if (i < 6) check_buttons("o_joy_data[0] digital0 map", got, 8'h1 << nes_bit[i]);
      else check_buttons("o_joy_data[0] digital1 map", got, 8'h1 << (7 - i));
    end
    @(posedge clk);
    i_ds2_p1 <= '1;
  endtask

  task automatic test_autofire(input int rep_bit, input int nes_bit);
    nes_buttons_t got;
    logic [1:0]   tail;
    logic         seen0;
    logic         seen1;
    seen0 = 1'b0;
    seen1 = 1'b0;
    @(posedge clk);
    i_ds2_p1 <= ds2_report_t'(~(16'h1 << rep_bit));
    repeat (4 * `NES_AUTOFIRE_PERIOD / 33 + 1) begin  // one read takes 33 cycles
      joy_read(0, got, tail);
      check_buttons("o_joy_data[0] other bits", got & ~(8'h1 << nes_bit), 8'h00);
      if (got[nes_bit]) seen1 = 1'b1;
      else seen0 = 1'b1;
    end
    if (!(seen0 && seen1)) begin
      errors++;
      $display("autofire on report bit %0d never toggled", rep_bit);
    end
    @(posedge clk);
    i_ds2_p1 <= '1;
    repeat (3) begin
      joy_read(0, got, tail);
      check_buttons("o_joy_data[0] after release", got, 8'h00);
    end
  endtask

  task automatic test_home_combo();
    int n;
    @(posedge clk);
    i_ds2_p1 <= ds2_report_t'(~16'h4100);  // Down and Select
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!o_soft_reset && n < 2);
    check_bit("o_soft_reset", o_soft_reset, 1'b1);
    @(posedge clk);
    i_ds2_p1 <= '1;
    repeat (2) @(negedge clk);
    check_bit("o_soft_reset", o_soft_reset, 1'b0);
    @(posedge clk);
    i_ds2_p2 <= ds2_report_t'(~16'h4100);
    repeat (4) @(negedge clk);
    check_bit("o_soft_reset player 2", o_soft_reset, 1'b0);
    @(posedge clk);
    i_ds2_p2 <= '1;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    i_wb         = '0;
    i_ds2_p1     = '1;
    i_ds2_p2     = '1;
    i_joy_strobe = '0;
    i_joy_clk    = '0;
    sys_resetn   = 1'b0;
    pad_btn[0]   = 8'h00;
    pad_btn[1]   = 8'h00;
    repeat (5) @(posedge clk);
    sys_resetn <= 1'b1;
    test_registers();
    test_host_buttons();
    test_nes_pad();
    test_ds2_mapping();
    test_autofire(7, 1);  // square on B
    test_autofire(4, 0);  // triangle on A
    test_home_combo();
    assert_fails = dut.u_host_regs.u_props.fail_cnt + dut.u_pad_p1.u_props.fail_cnt
                 + dut.u_pad_p2.u_props.fail_cnt;
    $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) $display("Simulation completed successfully");
    else $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/nes_input_pkg.sv
source/host_regs.sv
source/nes_pad_reader.sv
source/button_mapper.sv
source/joypad_port.sv
source/nes_input_top.sv
tests/nes_input_properties.sv
tests/tb_nes_input.sv

//--- Bender.yml
package:
  name: nes_input

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/nes_input_pkg.sv
      - source/host_regs.sv
      - source/nes_pad_reader.sv
      - source/button_mapper.sv
      - source/joypad_port.sv
      - source/nes_input_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/nes_input_properties.sv
      - tests/tb_nes_input.sv
